// File: design/spi_ctl_pkg.sv
////////////////////////////////////////////////////////////
// shared constants for the spi housekeeping block
// register frames are fixed at 16 bits, address byte first
// addresses outside the list below read zero, writes ignored
////////////////////////////////////////////////////////////

package spi_ctl_pkg;

  ////////////////////////////////////////////////////////////
  // frame format

  // address byte + data byte, msb first
  localparam int FRAME_BITS = 16;

  ////////////////////////////////////////////////////////////
  // register map

  // indicator, set/clear/toggle
  localparam logic [7:0] ADDR_LED      = 8'h07;
  // peripheral lane select, plain write
  localparam logic [7:0] ADDR_LANE_SEL = 8'h08;
  // 4094 output enable, set/clear/toggle
  localparam logic [7:0] ADDR_OE       = 8'h09;
  // write-only soft reset, data ignored
  localparam logic [7:0] ADDR_SOFT_RST = 8'h0B;

  // one led lit after power-up
  localparam logic [3:0] LED_RESET = 4'b0001;

  ////////////////////////////////////////////////////////////
  // data byte views

  // mask view for set/clear/toggle registers
  // a bit in both masks means toggle
  typedef struct packed {
    logic [3:0] clr_mask;
    logic [3:0] set_mask;
  } mask_word_t;

  // raw byte for plain registers, mask view for the rest
  typedef union packed {
    logic [7:0] raw;
    mask_word_t mask;
  } reg_word_u;

endpackage

// File: design/spi_frame_if.sv
////////////////////////////////////////////////////////////
// frame link from spi receiver to register bank
// wr_valid is a single-cycle pulse, the bank always accepts
// rd_data is combinational from rd_addr
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface spi_frame_if;

  // write side, one pulse per complete 16-bit frame
  logic                   wr_valid;
  logic [7:0]             wr_addr;
  spi_ctl_pkg::reg_word_u wr_data;

  // read side, address known after the first byte
  logic [7:0]             rd_addr;
  logic [7:0]             rd_data;

  // receiver end
  modport rx (
    output wr_valid, wr_addr, wr_data, rd_addr,
    input  rd_data
  );

  // register bank end
  modport bank (
    input  wr_valid, wr_addr, wr_data, rd_addr,
    output rd_data
  );

endinterface

// File: design/spi_slave.sv
////////////////////////////////////////////////////////////
// spi mode 0 register-link receiver, oversampled by cs
// sclk must stay at or below cs/8
// only frames of exactly 16 bits produce a write
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spi_slave
(
  input  logic    cs,
  input  logic    rst_n,
  input  logic    sclk,
  input  logic    ss_n,
  input  logic    mosi,
  output logic    miso_reg,
  spi_frame_if.rx frame
);

  localparam int FB    = spi_ctl_pkg::FRAME_BITS;
  localparam int CNT_W = $clog2(FB + 2);

  // counter sticks one past a full frame, marks over-long frames
  localparam logic [CNT_W-1:0] CNT_MAX  = CNT_W'(FB + 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FB);
  // count seen on the last address bit
  localparam logic [CNT_W-1:0] CNT_ADDR = CNT_W'(FB / 2 - 1);

  ////////////////////////////////////////////////////////////
  // pin synchronizers

  // [0],[1] are the two sync stages, [2] holds last value for edges
  logic [2:0]       sclk_sync;
  logic [2:0]       ss_sync;
  logic [1:0]       mosi_sync;

  logic             sclk_rise;
  logic             sclk_fall;
  logic             ss_rise;
  logic             selected;

  logic [CNT_W-1:0] bit_cnt;
  logic [FB-1:0]    rx_shift;
  logic [7:0]       tx_shift;
  // read data pending, loaded on next falling edge
  logic             tx_load;

  // ss_n idles high
  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk_sync <= '0;
      ss_sync   <= '1;
      mosi_sync <= '0;
    end
    else
    begin
      sclk_sync <= {sclk_sync[1:0], sclk};
      ss_sync   <= {ss_sync[1:0], ss_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
  assign ss_rise   = ss_sync[1] & ~ss_sync[2];
  assign selected  = ~ss_sync[1];

  ////////////////////////////////////////////////////////////
  // bit count, miso and write strobe

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt        <= '0;
      tx_load        <= 1'b0;
      tx_shift       <= '0;
      miso_reg       <= 1'b0;
      frame.wr_valid <= 1'b0;
    end
    else
    begin
      // old bit_cnt still visible here, cleared below in the same cycle
      frame.wr_valid <= ss_rise && (bit_cnt == CNT_FULL);
      if (!selected)
      begin
        // idle between frames, also drops aborted frames
        bit_cnt  <= '0;
        tx_load  <= 1'b0;
        tx_shift <= '0;
        miso_reg <= 1'b0;
      end
      else
      begin
        if (sclk_rise)
        begin
          if (bit_cnt != CNT_MAX)
            bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_ADDR)
            tx_load <= 1'b1;
        end
        if (sclk_fall)
        begin
          if (tx_load)
          begin
            // first data-phase bit, host samples on next rise
            miso_reg <= frame.rd_data[7];
            tx_shift <= {frame.rd_data[6:0], 1'b0};
            tx_load  <= 1'b0;
          end
          else
          begin
            // zero fill, miso low during address byte
            miso_reg <= tx_shift[7];
            tx_shift <= {tx_shift[6:0], 1'b0};
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // frame payload

  always_ff @(posedge cs)
  begin
    if (sclk_rise && selected)
    begin
      rx_shift <= {rx_shift[FB-2:0], mosi_sync[1]};
      // address byte complete, bank read starts now
      if (bit_cnt == CNT_ADDR)
        frame.rd_addr <= {rx_shift[6:0], mosi_sync[1]};
    end
    if (ss_rise)
    begin
      frame.wr_addr     <= rx_shift[FB-1 -: 8];
      frame.wr_data.raw <= rx_shift[7:0];
    end
  end

endmodule

// File: design/reg_bank.sv
////////////////////////////////////////////////////////////
// control registers behind the spi register link
// led and oe use set/clear/toggle, lane_sel is a plain write
// soft reset clears all three to zero, not to reset values
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reg_bank
(
  input  logic        cs,
  input  logic        rst_n,
  spi_frame_if.bank   frame,
  output logic [3:0]  led,
  output logic [3:0]  oe,
  output logic [7:0]  lane_sel
);

  ////////////////////////////////////////////////////////////
  // set/clear/toggle rule

  // any overlap turns the whole write into a toggle of those bits
  function automatic logic [3:0] apply_mask(
    input logic [3:0]             cur,
    input spi_ctl_pkg::reg_word_u w
  );
    logic [3:0] both;
    both = w.mask.set_mask & w.mask.clr_mask;
    if (|both)
      apply_mask = cur ^ both;
    else
      apply_mask = (cur | w.mask.set_mask) & ~w.mask.clr_mask;
  endfunction

  ////////////////////////////////////////////////////////////
  // write decode

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      led      <= spi_ctl_pkg::LED_RESET;
      oe       <= '0;
      lane_sel <= '0;
    end
    else if (frame.wr_valid)
    begin
      case (frame.wr_addr)
        spi_ctl_pkg::ADDR_LED:
          led <= apply_mask(led, frame.wr_data);
        spi_ctl_pkg::ADDR_LANE_SEL:
          lane_sel <= frame.wr_data.raw;
        spi_ctl_pkg::ADDR_OE:
          oe <= apply_mask(oe, frame.wr_data);
        spi_ctl_pkg::ADDR_SOFT_RST:
        begin
          // lane select drops too, any pass-through in progress ends
          led      <= '0;
          oe       <= '0;
          lane_sel <= '0;
        end
        default:
        begin
          // unimplemented address, nothing changes
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux

  // combinational, settled long before the next sclk fall
  always_comb
  begin
    case (frame.rd_addr)
      spi_ctl_pkg::ADDR_LED:      frame.rd_data = {4'h0, led};
      spi_ctl_pkg::ADDR_LANE_SEL: frame.rd_data = lane_sel;
      spi_ctl_pkg::ADDR_OE:       frame.rd_data = {4'h0, oe};
      // soft reset address is write only
      default:                    frame.rd_data = 8'h00;
    endcase
  end

endmodule

// File: design/periph_router.sv
////////////////////////////////////////////////////////////
// spi pass-through to peripheral lanes, purely combinational
// lane_sel n picks lane n-1, zero or n > N_LANES picks none
// CS_POLARITY bit set = active-high select, e.g. 4094 strobe
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module periph_router #(
  parameter int                 N_LANES     = 8,
  parameter logic [N_LANES-1:0] CS_POLARITY = N_LANES'(1)
)
(
  input  logic [7:0]         lane_sel,
  input  logic               ss2_n,
  input  logic               sclk,
  input  logic               mosi,
  input  logic               miso_reg,
  input  logic [N_LANES-1:0] lane_miso,
  output logic [N_LANES-1:0] lane_cs,
  output logic [N_LANES-1:0] lane_sclk,
  output logic [N_LANES-1:0] lane_mosi,
  output logic               miso
);

  // one-hot lane decode
  logic [N_LANES-1:0] lane_hot;
  // chosen lane while ss2_n is asserted
  logic [N_LANES-1:0] lane_act;

  always_comb
  begin
    for (int i = 0; i < N_LANES; i++)
      lane_hot[i] = (lane_sel == 8'(i + 1));
  end

  assign lane_act = lane_hot & {N_LANES{~ss2_n}};

  ////////////////////////////////////////////////////////////
  // host to lanes

  // idle lanes sit at inactive level: high for active-low, low otherwise
  assign lane_cs   = lane_act ^ ~CS_POLARITY;
  // clock and data held low on unselected lanes
  assign lane_sclk = lane_act & {N_LANES{sclk}};
  assign lane_mosi = lane_act & {N_LANES{mosi}};

  ////////////////////////////////////////////////////////////
  // lanes to host

  // register link owns miso unless ss2_n is low
  assign miso = ss2_n ? miso_reg : |(lane_hot & lane_miso);

endmodule

// File: design/spi_ctl_top.sv
////////////////////////////////////////////////////////////
// spi housekeeping top, register link on ss_n
// pass-through to peripheral lanes on ss2_n
// host sclk at most cs/8, no back-pressure
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spi_ctl_top #(
  parameter int                 N_LANES     = 8,
  parameter logic [N_LANES-1:0] CS_POLARITY = N_LANES'(1)
)
(
  input  logic               cs,
  input  logic               rst_n,
  input  logic               sclk,
  input  logic               ss_n,
  input  logic               ss2_n,
  input  logic               mosi,
  input  logic [N_LANES-1:0] lane_miso,
  output logic               miso,
  output logic [N_LANES-1:0] lane_cs,
  output logic [N_LANES-1:0] lane_sclk,
  output logic [N_LANES-1:0] lane_mosi,
  output logic [3:0]         led,
  output logic [3:0]         oe
);

  // register link miso before the lane merge
  logic       miso_reg;
  logic [7:0] lane_sel;

  spi_frame_if frame_if ();

  ////////////////////////////////////////////////////////////
  // register link

  spi_slave u_spi_slave (
    .cs       (cs),
    .rst_n    (rst_n),
    .sclk     (sclk),
    .ss_n     (ss_n),
    .mosi     (mosi),
    .miso_reg (miso_reg),
    .frame    (frame_if.rx)
  );

  reg_bank u_reg_bank (
    .cs       (cs),
    .rst_n    (rst_n),
    .frame    (frame_if.bank),
    .led      (led),
    .oe       (oe),
    .lane_sel (lane_sel)
  );

  ////////////////////////////////////////////////////////////
  // peripheral lanes

  periph_router #(
    .N_LANES     (N_LANES),
    .CS_POLARITY (CS_POLARITY)
  ) u_periph_router (
    .lane_sel  (lane_sel),
    .ss2_n     (ss2_n),
    .sclk      (sclk),
    .mosi      (mosi),
    .miso_reg  (miso_reg),
    .lane_miso (lane_miso),
    .lane_cs   (lane_cs),
    .lane_sclk (lane_sclk),
    .lane_mosi (lane_mosi),
    .miso      (miso)
  );

endmodule

// File: verif/spi_bfm.svh
////////////////////////////////////////////////////////////
// host side spi tasks, mode 0, msb first
// included inside the testbench module, uses its signals
////////////////////////////////////////////////////////////

`ifndef SPI_BFM_SVH
`define SPI_BFM_SVH

task automatic wait_cycles(input int n);
  repeat (n) @(posedge cs);
endtask

// random idle time between transfers
task automatic idle_gap();
  wait_cycles(HALF + ($urandom % 16));
endtask

// chosen lane carries the bit, the rest carry its inverse
function automatic logic [7:0] miso_drive(input logic [7:0] hot, input logic b);
  miso_drive = (hot & {8{b}}) | (~hot & {8{~b}});
endfunction

// register frame of nbits, miso sampled just before each rise
task automatic send_frame(input logic [15:0] word, input int nbits,
                          output logic [7:0] rd_byte);
  logic [15:0] rd_bits;
  rd_bits = '0;
  @(posedge cs);
  ss_n <= 1'b0;
  mosi <= word[15];
  wait_cycles(HALF);
  for (int i = 0; i < nbits; i++)
  begin
    @(negedge cs);
    rd_bits = {rd_bits[14:0], miso};
    @(posedge cs);
    sclk <= 1'b1;
    wait_cycles(HALF);
    sclk <= 1'b0;
    // next data bit goes out on the falling edge
    if (i < nbits - 1)
      mosi <= word[14 - i];
    wait_cycles(HALF);
  end
  ss_n <= 1'b1;
  mosi <= 1'b0;
  // last eight samples hold the data phase
  rd_byte = rd_bits[7:0];
endtask

// one byte through the router on ss2_n, lane pins checked per bit
task automatic pass_xfer(input logic [7:0] data, input logic [7:0] hot,
                         input logic [7:0] cs_act, output logic [7:0] rx);
  rx = '0;
  @(posedge cs);
  ss2_n     <= 1'b0;
  mosi      <= data[7];
  lane_miso <= miso_drive(hot, data[7]);
  wait_cycles(HALF);
  for (int i = 0; i < 8; i++)
  begin
    @(negedge cs);
    rx = {rx[6:0], miso};
    check_val("lane_cs", lane_cs, cs_act);
    check_val("lane_mosi", lane_mosi, hot & {8{data[7 - i]}});
    check_val("lane_sclk", lane_sclk, 8'h00);
    @(posedge cs);
    sclk <= 1'b1;
    @(negedge cs);
    // only the chosen lane sees the clock
    check_val("lane_sclk", lane_sclk, hot);
    wait_cycles(HALF);
    sclk <= 1'b0;
    if (i < 7)
    begin
      mosi      <= data[6 - i];
      lane_miso <= miso_drive(hot, data[6 - i]);
    end
    wait_cycles(HALF);
  end
  ss2_n     <= 1'b1;
  mosi      <= 1'b0;
  lane_miso <= '0;
endtask

`endif

// File: verif/spi_ctl_tb.sv
////////////////////////////////////////////////////////////
// testbench for spi_ctl_top with default parameters
// case file path is relative to the project root
// host sclk runs at cs/16 and stays below the cs/8 limit
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spi_ctl_tb;

  // host sclk half period in cs cycles
  localparam int HALF = 8;
  // only lane 0 has an active-high select by default
  localparam logic [7:0] CS_POL = 8'h01;
  // worst case per line covers a full frame plus gap and settle
  localparam int CASE_CYCLES = spi_ctl_pkg::FRAME_BITS * 2 * (HALF + 1) + 64;

  logic       cs;
  logic       rst_n;
  logic       sclk;
  logic       ss_n;
  logic       ss2_n;
  logic       mosi;
  logic [7:0] lane_miso;
  logic       miso;
  logic [7:0] lane_cs;
  logic [7:0] lane_sclk;
  logic [7:0] lane_mosi;
  logic [3:0] led;
  logic [3:0] oe;

  int errors    = 0;
  int n_pass    = 0;
  int n_fail    = 0;
  int cycle_cnt = 0;
  int limit     = 1000;

  // case table with addr, data and three expected bytes per line
  string       kind_q[$];
  logic [39:0] field_q[$];

  spi_ctl_top dut0 (
    .cs        (cs),
    .rst_n     (rst_n),
    .sclk      (sclk),
    .ss_n      (ss_n),
    .ss2_n     (ss2_n),
    .mosi      (mosi),
    .lane_miso (lane_miso),
    .miso      (miso),
    .lane_cs   (lane_cs),
    .lane_sclk (lane_sclk),
    .lane_mosi (lane_mosi),
    .led       (led),
    .oe        (oe)
  );

  task automatic check_val(input string name, input logic [7:0] act,
                           input logic [7:0] exp);
    if (act !== exp)
    begin
      $display("[FAIL] t=%0t %s actual=%h expected=%h", $time, name, act, exp);
      errors++;
    end
  endtask

  `include "spi_bfm.svh"

  ////////////////////////////////////////////////////////////
  // clock and watchdog

  initial
  begin
    cs = 1'b0;
    forever #10 cs = ~cs;
  end

  always @(posedge cs)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > limit)
    begin
      $display("timeout, run stopped after %0d cycles", cycle_cnt);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // case file and per-test bookkeeping

  task automatic read_cases();
    int         fd;
    int         n;
    string      line;
    string      kind;
    logic [7:0] f[5];
    fd = $fopen("verif/spi_ctl_cases.txt", "r");
    if (fd == 0)
    begin
      $display("case file verif/spi_ctl_cases.txt could not be opened");
      errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        n = $fgets(line, fd);
        // skip blank and comment lines
        if (n > 1 && line.substr(0, 0) != "#")
        begin
          if ($sscanf(line, "%s %h %h %h %h %h", kind, f[0], f[1], f[2], f[3], f[4]) == 6)
          begin
            kind_q.push_back(kind);
            field_q.push_back({f[0], f[1], f[2], f[3], f[4]});
          end
          else
          begin
            $display("malformed case line: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0)
      n_pass++;
    else
      n_fail++;
    $display("test %s: %s", name, (errors == err0) ? "ok" : "mismatch");
  endtask

  task automatic check_reset();
    int err0;
    err0 = errors;
    check_val("led", {4'h0, led}, {4'h0, spi_ctl_pkg::LED_RESET});
    check_val("oe", {4'h0, oe}, 8'h00);
    // idle select is the opposite of each lane's active level
    check_val("lane_cs", lane_cs, ~CS_POL);
    check_val("lane_sclk", lane_sclk, 8'h00);
    check_val("lane_mosi", lane_mosi, 8'h00);
    check_val("miso", {7'h0, miso}, 8'h00);
    report_test("reset", err0);
  endtask

  task automatic run_case(input int idx);
    string      kind;
    logic [7:0] a, b, c, d, e;
    logic [7:0] rd;
    logic [7:0] hot;
    int         err0;
    kind = kind_q[idx];
    {a, b, c, d, e} = field_q[idx];
    err0 = errors;
    idle_gap();
    if (kind == "frame" || kind == "short")
    begin
      send_frame({a, b}, (kind == "frame") ? spi_ctl_pkg::FRAME_BITS : 12, rd);
      // pin rise to register update is 4 cs cycles
      wait_cycles(4);
      @(negedge cs);
      check_val("led", {4'h0, led}, c);
      check_val("oe", {4'h0, oe}, d);
      if (kind == "frame")
        check_val("miso read byte", rd, e);
    end
    else if (kind == "pass")
    begin
      // lane_sel n drives lane n-1
      // ff in the file means no lane
      hot = (a == 8'hff) ? 8'h00 : (8'h01 << a[2:0]);
      pass_xfer(b, hot, c, rd);
      @(negedge cs);
      check_val("lane_cs", lane_cs, d);
      check_val("lane_sclk", lane_sclk, 8'h00);
      check_val("miso pass byte", rd, e);
    end
    else
    begin
      $display("case %0d has an unknown kind %s", idx, kind);
      errors++;
    end
    report_test($sformatf("%0d %s %h %h", idx, kind, a, b), err0);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    int seed;
    seed      = $urandom(32'h11b8_52d8);
    rst_n     = 1'b0;
    sclk      = 1'b0;
    ss_n      = 1'b1;
    ss2_n     = 1'b1;
    mosi      = 1'b0;
    lane_miso = '0;
    read_cases();
    limit = kind_q.size() * CASE_CYCLES + 1000;
    wait_cycles(8);
    rst_n <= 1'b1;
    @(negedge cs);
    check_reset();
    for (int i = 0; i < kind_q.size(); i++)
      run_case(i);
    $display("%0d tests passed, %0d tests failed, %0d mismatches", n_pass, n_fail, errors);
    if (errors == 0 && n_fail == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: verif/spi_ctl_cases.txt
# kind addr data exp_led exp_oe exp_rd, all hex; short frames ignore exp_rd
# pass: lane(ff none) mosi_byte exp_cs_active exp_cs_idle exp_miso_byte
frame 07 00 01 00 01
frame 07 02 03 00 01
frame 07 10 02 00 03
frame 07 36 00 00 02
frame 07 0c 0c 00 00
frame 07 55 09 00 0c
frame 09 0a 09 0a 00
frame 09 a5 09 05 0a
frame 09 ff 09 0a 05
frame 08 03 09 0a 00
frame 08 03 09 0a 03
frame 2a 77 09 0a 00
frame 0b 00 00 00 00
frame 08 00 00 00 00
frame 07 06 06 00 00
short 07 f0 06 00 00
frame 08 04 06 00 00
pass 03 a5 f6 fe a5
frame 08 01 06 00 04
pass 00 3c ff fe 3c
frame 08 00 06 00 01
pass ff 96 fe fe 00
frame 08 09 06 00 00
pass ff 5a fe fe 00

// File: tb.f
+incdir+verif
design/spi_ctl_pkg.sv
design/spi_frame_if.sv
design/spi_slave.sv
design/reg_bank.sv
design/periph_router.sv
design/spi_ctl_top.sv
verif/spi_ctl_tb.sv

// File: Bender.yml
package:
  name: spi_ctl

sources:
  - files:
      - design/spi_ctl_pkg.sv
      - design/spi_frame_if.sv
      - design/spi_slave.sv
      - design/reg_bank.sv
      - design/periph_router.sv
      - design/spi_ctl_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/spi_ctl_tb.sv
